//--- rtl/link_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial line and framing constants
// frame transmitter and frame receiver state encodings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package link_pkg;

	// frame delimiter, sent twice to open and twice to close
	localparam logic [7:0] DELIM = 8'h26;

	// clocks per bit when the top level is not told otherwise
	localparam int DEF_CLKS_PER_BIT = 16;

	typedef enum logic [2:0] {
		IDLE,
		OPEN1,
		OPEN2,
		FETCH,
		SEND,
		CLOSE1,
		CLOSE2,
		DONE
	} ftx_state_t;

	typedef enum logic [1:0] {
		HUNT,
		OPEN,
		BODY,
		CLOSE
	} frx_state_t;

endpackage

`default_nettype wire

//--- rtl/buf_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// string buffer widths and region layout
// arbiter client encoding
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package buf_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;

	// byte count of one payload, 0 to 128
	typedef logic [7:0] len_t;

	// lower half holds the outgoing string, upper half the received one
	localparam logic [ADDR_W-1:0] TX_BASE = 8'd0;
	localparam logic [ADDR_W-1:0] RX_BASE = 8'd128;
	localparam len_t REGION_LEN = 8'd128;

	typedef enum logic [1:0] {
		GNT_HOST = 2'd0,
		GNT_FTX  = 2'd1,
		GNT_FRX  = 2'd2
	} grant_t;

endpackage

`default_nettype wire

//--- rtl/buf_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic byte bus to the string buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface buf_bus_if;
	import buf_pkg::*;

	logic cyc;
	logic stb;
	logic we;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat_w;
	logic [DATA_W-1:0] dat_r;
	// one cycle per granted access
	logic ack;

	modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
	modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

//--- rtl/uart_tx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 serializer, one byte per request, done pulse after stop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = link_pkg::DEF_CLKS_PER_BIT
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire [buf_pkg::DATA_W-1:0] tx_byte,
	input wire tx_byte_req,
	output logic txd,
	output logic tx_byte_done
);
	import buf_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	logic active;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0] bit_cnt;
	// stop, data, start; bit 0 is on the line, ones shift in behind
	logic [DATA_W+1:0] shreg;

	assign txd = shreg[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			shreg <= '1;
			tx_byte_done <= 1'b0;
		end else begin
			tx_byte_done <= 1'b0;
			if (!active) begin
				// requests while shifting are dropped
				if (tx_byte_req) begin
					active <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= '0;
					shreg <= {1'b1, tx_byte, 1'b0};
				end
			end else if (clk_cnt == BIT_LAST) begin
				clk_cnt <= '0;
				shreg <= {1'b1, shreg[DATA_W+1:1]};
				if (bit_cnt == 4'd9) begin
					active <= 1'b0;
					tx_byte_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/uart_rx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 deserializer with input synchronizer
// start check at half a bit, data sampled at bit centres
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = link_pkg::DEF_CLKS_PER_BIT
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire rxd,
	output logic [buf_pkg::DATA_W-1:0] rx_byte,
	output logic rx_byte_vld
);
	import buf_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic active;
	logic [CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_cnt;
	logic sample;

	assign sample = active && (clk_cnt == ((bit_cnt == 4'd0) ? HALF_LAST : BIT_LAST));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			if (!active) begin
				if (rx_prev && !rx_sync) begin
					active <= 1'b1;
					clk_cnt <= '0;
					bit_cnt <= '0;
				end
			end else if (sample) begin
				clk_cnt <= '0;
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 4'd0 && rx_sync) begin
					// line went high again, just a glitch
					active <= 1'b0;
				end else if (bit_cnt == 4'd9) begin
					active <= 1'b0;
					// bad stop bit drops the byte
					rx_byte_vld <= rx_sync;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9)
			rx_byte <= {rx_sync, rx_byte[DATA_W-1:1]};
	end

endmodule

`default_nettype wire

//--- rtl/frame_tx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame transmitter: two delimiters, payload from the buffer,
// two delimiters; payload bytes are prefetched over Wishbone
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module frame_tx (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire tx_req,
	input wire buf_pkg::len_t tx_length,
	output logic tx_busy,
	output logic tx_done,
	buf_bus_if.master bus,
	output logic [buf_pkg::DATA_W-1:0] tx_byte,
	output logic tx_byte_req,
	input wire tx_byte_done
);
	import link_pkg::*;
	import buf_pkg::*;

	ftx_state_t state;
	len_t len_q;
	// bytes fetched so far
	len_t fetch_idx;
	logic have_byte;
	logic [DATA_W-1:0] next_byte;
	logic fetching;

	assign fetching = (state inside {OPEN1, OPEN2, FETCH, SEND}) && !have_byte
		&& (fetch_idx != len_q);

	assign bus.cyc = fetching;
	assign bus.stb = fetching;
	assign bus.we = 1'b0;
	assign bus.adr = TX_BASE + fetch_idx;
	assign bus.dat_w = '0;

	assign tx_busy = (state != IDLE) && (state != DONE);
	assign tx_done = (state == DONE);

	always_ff @(posedge sys_clk) begin
		if (fetching && bus.ack)
			next_byte <= bus.dat_r;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= IDLE;
			len_q <= '0;
			fetch_idx <= '0;
			have_byte <= 1'b0;
			tx_byte <= '0;
			tx_byte_req <= 1'b0;
		end else begin
			tx_byte_req <= 1'b0;
			if (fetching && bus.ack) begin
				have_byte <= 1'b1;
				fetch_idx <= fetch_idx + 1'b1;
			end
			case (state)
				IDLE: if (tx_req) begin
					state <= OPEN1;
					len_q <= tx_length;
					fetch_idx <= '0;
					have_byte <= 1'b0;
					tx_byte <= DELIM;
					tx_byte_req <= 1'b1;
				end
				OPEN1: if (tx_byte_done) begin
					state <= OPEN2;
					tx_byte <= DELIM;
					tx_byte_req <= 1'b1;
				end
				// all fetched and nothing held back means the payload is out
				OPEN2, SEND: if (tx_byte_done) begin
					if (fetch_idx == len_q && !have_byte) begin
						state <= CLOSE1;
						tx_byte <= DELIM;
						tx_byte_req <= 1'b1;
					end else begin
						state <= FETCH;
					end
				end
				FETCH: if (have_byte) begin
					state <= SEND;
					have_byte <= 1'b0;
					tx_byte <= next_byte;
					tx_byte_req <= 1'b1;
				end
				CLOSE1: if (tx_byte_done) begin
					state <= CLOSE2;
					tx_byte <= DELIM;
					tx_byte_req <= 1'b1;
				end
				CLOSE2: if (tx_byte_done)
					state <= DONE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/frame_rx.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame receiver: hunts for the opening delimiter pair, writes
// the payload into the receive region, reports its length
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module frame_rx (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire [buf_pkg::DATA_W-1:0] rx_byte,
	input wire rx_byte_vld,
	output buf_pkg::len_t rx_length,
	output logic rx_done,
	buf_bus_if.master bus
);
	import link_pkg::*;
	import buf_pkg::*;

	frx_state_t state;
	len_t count;
	logic pend;
	// second byte of a stray delimiter, written after the first
	logic extra;
	logic [DATA_W-1:0] extra_dat;
	logic done_wait;
	logic [ADDR_W-1:0] wr_adr;
	logic [DATA_W-1:0] wr_dat;

	assign bus.cyc = pend;
	assign bus.stb = pend;
	assign bus.we = 1'b1;
	assign bus.adr = wr_adr;
	assign bus.dat_w = wr_dat;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= HUNT;
			count <= '0;
			pend <= 1'b0;
			extra <= 1'b0;
			extra_dat <= '0;
			done_wait <= 1'b0;
			wr_adr <= '0;
			wr_dat <= '0;
			rx_length <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (pend && bus.ack) begin
				pend <= 1'b0;
				if (done_wait) begin
					done_wait <= 1'b0;
					rx_done <= 1'b1;
					rx_length <= count;
				end
			end else if (extra && !pend) begin
				pend <= 1'b1;
				wr_adr <= RX_BASE + count;
				wr_dat <= extra_dat;
				count <= count + 1'b1;
				extra <= 1'b0;
			end
			if (rx_byte_vld) begin
				case (state)
					HUNT: if (rx_byte == DELIM)
						state <= OPEN;
					OPEN: if (rx_byte == DELIM) begin
						state <= BODY;
						count <= '0;
					end else begin
						state <= HUNT;
					end
					// bytes past the region are dropped, count saturates
					BODY: if (rx_byte == DELIM) begin
						state <= CLOSE;
					end else if (count != REGION_LEN) begin
						pend <= 1'b1;
						wr_adr <= RX_BASE + count;
						wr_dat <= rx_byte;
						count <= count + 1'b1;
					end
					CLOSE: if (rx_byte == DELIM) begin
						state <= HUNT;
						if (pend) begin
							done_wait <= 1'b1;
						end else begin
							rx_done <= 1'b1;
							rx_length <= count;
						end
					end else begin
						state <= BODY;
						if (count != REGION_LEN) begin
							pend <= 1'b1;
							wr_adr <= RX_BASE + count;
							wr_dat <= DELIM;
							count <= count + 1'b1;
							if (count + 8'd1 != REGION_LEN) begin
								extra <= 1'b1;
								extra_dat <= rx_byte;
							end
						end
					end
					default: state <= HUNT;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/string_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 256-byte string RAM shared by host and both framers
// round-robin arbiter, one access per grant, ack a cycle later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module string_buffer (
	input wire sys_clk,
	input wire sys_rst_n,
	buf_bus_if.slave host,
	buf_bus_if.slave ftx,
	buf_bus_if.slave frx
);
	import buf_pkg::*;

	logic [DATA_W-1:0] ram [2**ADDR_W];
	logic [DATA_W-1:0] rd_data;
	logic [2:0] req;
	logic [2:0] ack_vec;
	grant_t last;
	grant_t pick;
	logic pick_vld;
	logic grant_now;
	logic sel_we;
	logic [ADDR_W-1:0] sel_adr;
	logic [DATA_W-1:0] sel_dat_w;

	assign req[GNT_HOST] = host.cyc & host.stb;
	assign req[GNT_FTX] = ftx.cyc & ftx.stb;
	assign req[GNT_FRX] = frx.cyc & frx.stb;

	// search starts with the client after the one served last
	always_comb begin
		grant_t cand;
		pick = last;
		pick_vld = 1'b0;
		for (int i = 1; i <= 3; i++) begin
			cand = grant_t'((int'(last) + i) % 3);
			if (!pick_vld && req[cand]) begin
				pick = cand;
				pick_vld = 1'b1;
			end
		end
	end

	always_comb begin
		case (pick)
			GNT_FTX: begin
				sel_we = ftx.we;
				sel_adr = ftx.adr;
				sel_dat_w = ftx.dat_w;
			end
			GNT_FRX: begin
				sel_we = frx.we;
				sel_adr = frx.adr;
				sel_dat_w = frx.dat_w;
			end
			default: begin
				sel_we = host.we;
				sel_adr = host.adr;
				sel_dat_w = host.dat_w;
			end
		endcase
	end

	// no new grant in an ack cycle, the acked master still holds stb
	assign grant_now = pick_vld && (ack_vec == 3'b000);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			last <= GNT_FRX;
			ack_vec <= '0;
		end else begin
			ack_vec <= '0;
			if (grant_now) begin
				last <= pick;
				ack_vec[pick] <= 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (grant_now) begin
			if (sel_we)
				ram[sel_adr] <= sel_dat_w;
			rd_data <= ram[sel_adr];
		end
	end

	assign host.dat_r = rd_data;
	assign ftx.dat_r = rd_data;
	assign frx.dat_r = rd_data;
	assign host.ack = ack_vec[GNT_HOST];
	assign ftx.ack = ack_vec[GNT_FTX];
	assign frx.ack = ack_vec[GNT_FRX];

endmodule

`default_nettype wire

//--- rtl/uart_string_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framed string link top level
// host Wishbone port, shared buffer, framers, UART halves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module uart_string_top #(
	parameter int CLKS_PER_BIT = link_pkg::DEF_CLKS_PER_BIT
) (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire host_cyc,
	input wire host_stb,
	input wire host_we,
	input wire [buf_pkg::ADDR_W-1:0] host_adr,
	input wire [buf_pkg::DATA_W-1:0] host_dat_w,
	output wire [buf_pkg::DATA_W-1:0] host_dat_r,
	output wire host_ack,
	input wire tx_req,
	input wire buf_pkg::len_t tx_length,
	output wire tx_busy,
	output wire tx_done,
	output wire buf_pkg::len_t rx_length,
	output wire rx_done,
	input wire uart_rxd,
	output wire uart_txd
);
	import buf_pkg::*;

	buf_bus_if host_bus ();
	buf_bus_if ftx_bus ();
	buf_bus_if frx_bus ();

	wire [DATA_W-1:0] tx_byte;
	wire tx_byte_req;
	wire tx_byte_done;
	wire [DATA_W-1:0] rx_byte;
	wire rx_byte_vld;

	// host port is the master side of host_bus
	assign host_bus.cyc = host_cyc;
	assign host_bus.stb = host_stb;
	assign host_bus.we = host_we;
	assign host_bus.adr = host_adr;
	assign host_bus.dat_w = host_dat_w;
	assign host_dat_r = host_bus.dat_r;
	assign host_ack = host_bus.ack;

	string_buffer u_string_buffer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.host      (host_bus.slave),
		.ftx       (ftx_bus.slave),
		.frx       (frx_bus.slave)
	);

	frame_tx u_frame_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_req       (tx_req),
		.tx_length    (tx_length),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.bus          (ftx_bus.master),
		.tx_byte      (tx_byte),
		.tx_byte_req  (tx_byte_req),
		.tx_byte_done (tx_byte_done)
	);

	frame_rx u_frame_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_length   (rx_length),
		.rx_done     (rx_done),
		.bus         (frx_bus.master)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_byte      (tx_byte),
		.tx_byte_req  (tx_byte_req),
		.txd          (uart_txd),
		.tx_byte_done (tx_byte_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rxd         (uart_rxd),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld)
	);

endmodule

`default_nettype wire

//--- verif/tb_uart_string.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the framed string link
// serial line driver and monitor, host bus tasks
// directed tests and cycle limit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_uart_string;
	import buf_pkg::*;
	import link_pkg::*;

	localparam int CLKS_PER_BIT = 8;
	localparam int TX_LEN = 12;
	localparam int RX_LEN = 12;
	localparam int CC_LEN = 20;
	localparam int OVF_LEN = 130;
	// every byte on the line, both directions, junk bytes included
	localparam int LINE_BYTES = (TX_LEN + 4) + 4 + (4 + RX_LEN + 4) + 2 * (CC_LEN + 4)
		+ (OVF_LEN + 4);
	// host bus traffic and gaps between tests
	localparam int MARGIN = 8000;
	localparam int TIMEOUT_CYCLES = LINE_BYTES * 10 * CLKS_PER_BIT + MARGIN;

	typedef logic [DATA_W-1:0] byte_q_t [$];

	logic sys_clk;
	logic sys_rst_n;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	logic [ADDR_W-1:0] host_adr;
	logic [DATA_W-1:0] host_dat_w;
	wire [DATA_W-1:0] host_dat_r;
	wire host_ack;
	logic tx_req;
	len_t tx_length;
	wire tx_busy;
	wire tx_done;
	len_t rx_length;
	wire rx_done;
	logic uart_rxd;
	wire uart_txd;
	int cycle_cnt;
	int seed;
	logic links_idle;

	uart_string_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_string_top (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.host_cyc   (host_cyc),
		.host_stb   (host_stb),
		.host_we    (host_we),
		.host_adr   (host_adr),
		.host_dat_w (host_dat_w),
		.host_dat_r (host_dat_r),
		.host_ack   (host_ack),
		.tx_req     (tx_req),
		.tx_length  (tx_length),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.rx_length  (rx_length),
		.rx_done    (rx_done),
		.uart_rxd   (uart_rxd),
		.uart_txd   (uart_txd)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [DATA_W-1:0] actual,
			input logic [DATA_W-1:0] expected);
		if (actual !== expected)
			abort_run($sformatf("** Error at %0t: %s is 0x%h, expected 0x%h",
				$time, name, actual, expected));
	endtask

	task automatic check_len(input string name, input len_t actual, input len_t expected);
		if (actual !== expected)
			abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			abort_run($sformatf("** Error at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
	endtask

	// odd multiplier, so every address bit changes the value
	function automatic logic [DATA_W-1:0] fill_byte(input int adr);
		return DATA_W'(adr * 37 + 11);
	endfunction

	task automatic make_payload(input int len, output byte_q_t pl);
		logic [DATA_W-1:0] b;
		pl = {};
		repeat (len) begin
			b = DATA_W'($random(seed));
			// the link cannot carry the delimiter inside a payload
			if (b == DELIM)
				b = "a";
			pl.push_back(b);
		end
	endtask

	// one Wishbone classic access, then an idle cycle with ack low
	task automatic host_access(input logic we, input int adr, input logic [DATA_W-1:0] wdat,
			output logic [DATA_W-1:0] rdat);
		int waited;
		waited = 0;
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		host_we <= we;
		host_adr <= ADDR_W'(adr);
		host_dat_w <= wdat;
		do begin
			@(posedge sys_clk);
			waited++;
			if (waited > 8)
				abort_run("host bus access got no ack within 8 cycles");
		end while (!host_ack);
		rdat = host_dat_r;
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we <= 1'b0;
		@(posedge sys_clk);
		check_flag("host_ack", host_ack, 1'b0);
	endtask

	task automatic host_write(input int adr, input logic [DATA_W-1:0] dat);
		logic [DATA_W-1:0] unused_rd;
		host_access(1'b1, adr, dat, unused_rd);
	endtask

	task automatic host_read(input int adr, output logic [DATA_W-1:0] dat);
		host_access(1'b0, adr, '0, dat);
	endtask

	// start, 8 data bits LSB first, stop
	task automatic drive_line_byte(input logic [DATA_W-1:0] b);
		logic [DATA_W+1:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < DATA_W + 2; i++) begin
			uart_rxd <= bits[i];
			repeat (CLKS_PER_BIT) @(posedge sys_clk);
		end
	endtask

	task automatic drive_frame(input byte_q_t pl);
		drive_line_byte(DELIM);
		drive_line_byte(DELIM);
		foreach (pl[i])
			drive_line_byte(pl[i]);
		drive_line_byte(DELIM);
		drive_line_byte(DELIM);
	endtask

	task automatic read_line_byte(output logic [DATA_W-1:0] b);
		@(posedge sys_clk);
		while (uart_txd)
			@(posedge sys_clk);
		// first low sample, move on to the centre of the start bit
		repeat (CLKS_PER_BIT / 2 - 1) @(posedge sys_clk);
		if (uart_txd)
			abort_run("start bit on uart_txd ended before its centre");
		for (int i = 0; i < DATA_W; i++) begin
			repeat (CLKS_PER_BIT) @(posedge sys_clk);
			b[i] = uart_txd;
		end
		repeat (CLKS_PER_BIT) @(posedge sys_clk);
		if (!uart_txd)
			abort_run("stop bit on uart_txd was low");
	endtask

	task automatic expect_tx_frame(input byte_q_t pl);
		byte_q_t exp;
		logic [DATA_W-1:0] got;
		exp = {};
		exp.push_back(DELIM);
		exp.push_back(DELIM);
		foreach (pl[i])
			exp.push_back(pl[i]);
		exp.push_back(DELIM);
		exp.push_back(DELIM);
		foreach (exp[i]) begin
			read_line_byte(got);
			check_byte($sformatf("uart_txd byte %0d", i), got, exp[i]);
		end
	endtask

	// busy from the cycle after tx_req until tx_done, done for one cycle
	task automatic watch_tx_status();
		@(posedge sys_clk);
		check_flag("tx_busy", tx_busy, 1'b1);
		while (!tx_done) begin
			@(posedge sys_clk);
			if (!tx_done)
				check_flag("tx_busy", tx_busy, 1'b1);
		end
		check_flag("tx_busy", tx_busy, 1'b0);
		@(posedge sys_clk);
		check_flag("tx_done", tx_done, 1'b0);
	endtask

	task automatic load_tx_region(input byte_q_t pl);
		foreach (pl[i])
			host_write(int'(TX_BASE) + i, pl[i]);
	endtask

	task automatic send_frame(input byte_q_t pl);
		tx_length <= len_t'(pl.size());
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		fork
			expect_tx_frame(pl);
			watch_tx_status();
		join
	endtask

	task automatic wait_rx_done(input len_t exp_len);
		@(posedge sys_clk);
		while (!rx_done)
			@(posedge sys_clk);
		check_len("rx_length", rx_length, exp_len);
		@(posedge sys_clk);
		check_flag("rx_done", rx_done, 1'b0);
	endtask

	task automatic receive_frame(input byte_q_t pl, input len_t exp_len);
		fork
			drive_frame(pl);
			wait_rx_done(exp_len);
		join
	endtask

	task automatic check_rx_region(input byte_q_t pl, input int len);
		logic [DATA_W-1:0] got;
		for (int i = 0; i < len; i++) begin
			host_read(int'(RX_BASE) + i, got);
			check_byte($sformatf("rx buffer[%0d]", i), got, pl[i]);
		end
	endtask

	task automatic test_reset();
		check_flag("uart_txd", uart_txd, 1'b1);
		check_flag("tx_busy", tx_busy, 1'b0);
		check_flag("tx_done", tx_done, 1'b0);
		check_flag("rx_done", rx_done, 1'b0);
		check_flag("host_ack", host_ack, 1'b0);
	endtask

	task automatic test_host_bus();
		logic [DATA_W-1:0] got;
		for (int a = 0; a < 2 ** ADDR_W; a++)
			host_write(a, fill_byte(a));
		for (int a = 0; a < 2 ** ADDR_W; a++) begin
			host_read(a, got);
			check_byte($sformatf("buffer[%0d]", a), got, fill_byte(a));
		end
	endtask

	task automatic test_send(input int len);
		byte_q_t pl;
		make_payload(len, pl);
		load_tx_region(pl);
		send_frame(pl);
	endtask

	task automatic test_receive();
		byte_q_t pl;
		make_payload(RX_LEN, pl);
		// noise before the opening pair, including a lone delimiter
		drive_line_byte("x");
		drive_line_byte("a");
		drive_line_byte(DELIM);
		drive_line_byte("b");
		receive_frame(pl, len_t'(RX_LEN));
		check_rx_region(pl, RX_LEN);
	endtask

	task automatic test_concurrency();
		byte_q_t tx_pl;
		byte_q_t rx_pl;
		logic [DATA_W-1:0] got;
		int k;
		make_payload(CC_LEN, tx_pl);
		make_payload(CC_LEN, rx_pl);
		load_tx_region(tx_pl);
		links_idle = 1'b0;
		k = 0;
		fork
			begin
				fork
					send_frame(tx_pl);
					receive_frame(rx_pl, len_t'(CC_LEN));
				join
				links_idle = 1'b1;
			end
			// host keeps the arbiter busy the whole time
			while (!links_idle) begin
				host_read(int'(TX_BASE) + k % CC_LEN, got);
				check_byte("host_dat_r", got, tx_pl[k % CC_LEN]);
				k++;
			end
		join
		check_rx_region(rx_pl, CC_LEN);
	endtask

	task automatic test_overflow();
		byte_q_t pl;
		make_payload(OVF_LEN, pl);
		receive_frame(pl, REGION_LEN);
		check_rx_region(pl, int'(REGION_LEN));
	endtask

	initial begin
		seed = 32'hf566;
		links_idle = 1'b0;
		sys_rst_n <= 1'b0;
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we <= 1'b0;
		host_adr <= '0;
		host_dat_w <= '0;
		tx_req <= 1'b0;
		tx_length <= '0;
		uart_rxd <= 1'b1;
		repeat (5) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		test_reset();
		test_host_bus();
		test_send(TX_LEN);
		test_send(0);
		test_receive();
		test_concurrency();
		test_overflow();
		$display("Result: PASSED");
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles, a test never finished", cycle_cnt);
		$display("Result: FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- all.f
rtl/link_pkg.sv
rtl/buf_pkg.sv
rtl/buf_bus_if.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/frame_tx.sv
rtl/frame_rx.sv
rtl/string_buffer.sv
rtl/uart_string_top.sv
verif/tb_uart_string.sv

//--- Makefile
# Verilator build and run for the framed string link

VERILATOR ?= verilator
TOP ?= tb_uart_string
RTL_TOP ?= uart_string_top
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(shell grep '^rtl/' $(FILELIST))

clean:
	rm -rf $(BUILD_DIR) $(LOG)
